//--- alu_top.f
+incdir+verilog
verilog/alu_pkg.sv
verilog/alu_operand_stage.sv
verilog/alu_nibble_slice.sv
verilog/alu_result_stage.sv
verilog/alu_top.v
dv/alu_checker.sv
dv/alu_tb.sv

//--- dv/alu_checker.sv
`timescale 1ns/1ps
`include "alu_settings.svh"

module alu_checker (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     in_valid,
  input  logic                     in_ready,
  input  logic                     out_valid,
  input  logic                     out_ready,
  input  logic [`ALU_WIDTH-1:0]    s,
  input  logic                     overflow,
  input  logic                     zero
);

  logic [`ALU_OP_WIDTH-1:0] exp_op [$];
  logic [`ALU_WIDTH-1:0]    exp_s [$];
  logic                     exp_ovf [$];
  logic                     exp_zero [$];
  logic                     exp_timed [$];
  int                       accept_cycle [$];
  int                       cycle_count = 0;
  int                       test_count = 0;
  int                       error_count = 0;

  task automatic push_expected(input logic [`ALU_OP_WIDTH-1:0] e_op,
                               input logic [`ALU_WIDTH-1:0] e_s,
                               input logic e_ovf,
                               input logic e_zero,
                               input logic e_timed);
    exp_op.push_back(e_op);
    exp_s.push_back(e_s);
    exp_ovf.push_back(e_ovf);
    exp_zero.push_back(e_zero);
    exp_timed.push_back(e_timed);
  endtask

  function automatic int pending_count();
    return exp_s.size();
  endfunction

  task automatic check_output();
    logic [`ALU_OP_WIDTH-1:0] want_op;
    logic [`ALU_WIDTH-1:0]    want_s;
    logic                     want_ovf;
    logic                     want_zero;
    logic                     timed;
    int                       latency;
    int                       errs;
    if (exp_s.size() == 0) begin
      $display("result %h arrived with no test pending", s);
      error_count++;
      return;
    end
    want_op   = exp_op.pop_front();
    want_s    = exp_s.pop_front();
    want_ovf  = exp_ovf.pop_front();
    want_zero = exp_zero.pop_front();
    timed     = exp_timed.pop_front();
    latency   = (accept_cycle.size() > 0) ? cycle_count - accept_cycle.pop_front() : -1;
    errs      = 0;
    if (s !== want_s) begin
      $display("mismatch test %0d s: got %h expected %h", test_count, s, want_s);
      errs++;
    end
    if (overflow !== want_ovf) begin
      $display("mismatch test %0d overflow: got %h expected %h", test_count, overflow, want_ovf);
      errs++;
    end
    if (zero !== want_zero) begin
      $display("mismatch test %0d zero: got %h expected %h", test_count, zero, want_zero);
      errs++;
    end
    // With out_ready held high the pipe is exactly two deep
    if (timed && latency != 2) begin
      $display("test %0d result came %0d cycles after acceptance instead of 2",
               test_count, latency);
      errs++;
    end
    $display("test %0d op %0d: %s", test_count, want_op, (errs == 0) ? "ok" : "FAIL");
    error_count += errs;
    test_count++;
  endtask

  // Sampled mid-cycle, ahead of the edge that completes each handshake
  always @(negedge clk) begin
    if (rst_n) begin
      cycle_count++;
      if (in_valid && in_ready) begin
        accept_cycle.push_back(cycle_count);
      end
      if (out_valid && out_ready) begin
        check_output();
      end
    end
  end

endmodule

//--- dv/alu_tb.sv
`timescale 1ns/1ps
`include "alu_settings.svh"

module alu_tb;

  logic                     clk;
  logic                     rst_n;
  logic                     in_valid;
  logic                     in_ready;
  logic [`ALU_OP_WIDTH-1:0] op;
  logic [`ALU_WIDTH-1:0]    a;
  logic [`ALU_WIDTH-1:0]    b;
  logic                     out_valid;
  logic                     out_ready;
  logic [`ALU_WIDTH-1:0]    s;
  logic                     overflow;
  logic                     zero;
  logic                     stall_mode;
  logic [31:0]              lfsr_state;

  // Stimulus table columns
  logic [`ALU_OP_WIDTH-1:0] row_op [$];
  logic [`ALU_WIDTH-1:0]    row_a [$];
  logic [`ALU_WIDTH-1:0]    row_b [$];
  logic [`ALU_WIDTH-1:0]    row_s [$];
  logic                     row_ovf [$];
  logic                     row_zero [$];

  alu_top dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .op        (op),
    .a         (a),
    .b         (b),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .s         (s),
    .overflow  (overflow),
    .zero      (zero)
  );

  alu_checker chk0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .s         (s),
    .overflow  (overflow),
    .zero      (zero)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] v);
    return v[0] ? ((v >> 1) ^ 32'h8020_0003) : (v >> 1);
  endfunction

  // Output stalls, one LFSR step per ready bit
  always @(posedge clk) begin
    if (stall_mode) begin
      lfsr_state = lfsr_next(lfsr_state);
      #1;
      out_ready = lfsr_state[0];
    end else begin
      #1;
      out_ready = 1'b1;
    end
  end

  task automatic add_row(input logic [3:0] r_op, input logic [15:0] r_a, input logic [15:0] r_b,
                         input logic [15:0] r_s, input logic r_ovf, input logic r_zero);
    row_op.push_back(r_op);
    row_a.push_back(r_a);
    row_b.push_back(r_b);
    row_s.push_back(r_s);
    row_ovf.push_back(r_ovf);
    row_zero.push_back(r_zero);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table: op, a, b, then expected s, overflow, zero
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_table();
    add_row(4'd0, 16'h0005, 16'h0003, 16'h0002, 1'b1, 1'b0);
    add_row(4'd0, 16'h0003, 16'h0005, 16'hFFFE, 1'b0, 1'b0);
    add_row(4'd0, 16'h1234, 16'h1234, 16'h0000, 1'b1, 1'b1);
    add_row(4'd1, 16'h0003, 16'h0004, 16'h0007, 1'b0, 1'b0);
    add_row(4'd1, 16'h7FFF, 16'h0001, 16'h8000, 1'b1, 1'b0);
    add_row(4'd1, 16'h8000, 16'h8000, 16'h0000, 1'b1, 1'b1);
    add_row(4'd2, 16'h00F0, 16'h0F0F, 16'h0FFF, 1'b0, 1'b0);
    add_row(4'd3, 16'hF0F0, 16'h3C3C, 16'h3030, 1'b0, 1'b0);
    add_row(4'd3, 16'hAAAA, 16'h5555, 16'h0000, 1'b0, 1'b1);
    add_row(4'd4, 16'h0000, 16'h0000, 16'hFFFF, 1'b0, 1'b0);
    add_row(4'd4, 16'h0005, 16'h0000, 16'h0004, 1'b1, 1'b0);
    add_row(4'd5, 16'h0041, 16'h0000, 16'h0042, 1'b0, 1'b0);
    add_row(4'd5, 16'hFFFF, 16'h0000, 16'h0000, 1'b1, 1'b1);
    add_row(4'd6, 16'h00FF, 16'h0000, 16'hFF00, 1'b0, 1'b0);
    add_row(4'd6, 16'hFFFF, 16'h0000, 16'h0000, 1'b0, 1'b1);
    // Shifts of one pattern by 0, 3, 15 and a saturating amount
    add_row(4'd7, 16'h8C31, 16'h0000, 16'h8C31, 1'b0, 1'b0);
    add_row(4'd7, 16'h8C31, 16'h0003, 16'h6188, 1'b0, 1'b0);
    add_row(4'd7, 16'h8C31, 16'h000F, 16'h8000, 1'b0, 1'b0);
    add_row(4'd7, 16'h8C31, 16'h0010, 16'h0000, 1'b0, 1'b1);
    add_row(4'd8, 16'h8C31, 16'h0000, 16'h8C31, 1'b0, 1'b0);
    add_row(4'd8, 16'h8C31, 16'h0003, 16'hF186, 1'b0, 1'b0);
    add_row(4'd8, 16'h8C31, 16'h000F, 16'hFFFF, 1'b0, 1'b0);
    add_row(4'd8, 16'h8C31, 16'h0010, 16'hFFFF, 1'b0, 1'b0);
    add_row(4'd8, 16'h8000, 16'h0014, 16'hFFFF, 1'b0, 1'b0);
    add_row(4'd9, 16'h8C31, 16'h0000, 16'h8C31, 1'b0, 1'b0);
    add_row(4'd9, 16'h8C31, 16'h0003, 16'h6188, 1'b0, 1'b0);
    add_row(4'd9, 16'h8C31, 16'h000F, 16'h8000, 1'b0, 1'b0);
    add_row(4'd9, 16'h8C31, 16'h8003, 16'h0000, 1'b0, 1'b1);
    add_row(4'd10, 16'h8C31, 16'h0000, 16'h8C31, 1'b0, 1'b0);
    add_row(4'd10, 16'h8C31, 16'h0003, 16'h1186, 1'b0, 1'b0);
    add_row(4'd10, 16'h8C31, 16'h000F, 16'h0001, 1'b0, 1'b0);
    add_row(4'd10, 16'h8C31, 16'h0014, 16'h0000, 1'b0, 1'b1);
    add_row(4'd11, 16'h0007, 16'h0007, 16'h0001, 1'b1, 1'b0);
    add_row(4'd11, 16'h0003, 16'h0009, 16'h0001, 1'b0, 1'b0);
    add_row(4'd11, 16'h0009, 16'h0003, 16'h0000, 1'b1, 1'b1);
    add_row(4'd11, 16'hFFFE, 16'h0002, 16'h0001, 1'b1, 1'b0);
    add_row(4'd12, 16'h1234, 16'h5678, 16'h0000, 1'b0, 1'b1);
    add_row(4'd15, 16'hFFFF, 16'hFFFF, 16'h0000, 1'b0, 1'b1);
  endtask

  // Each row stays on the inputs until the edge that accepts it
  task automatic run_rows(input logic timed);
    logic took;
    for (int i = 0; i < row_s.size(); i++) begin
      chk0.push_expected(row_op[i], row_s[i], row_ovf[i], row_zero[i], timed);
      in_valid = 1'b1;
      op       = row_op[i];
      a        = row_a[i];
      b        = row_b[i];
      took     = 1'b0;
      while (!took) begin
        @(negedge clk);
        took = in_ready;
        @(posedge clk);
      end
      #1;
    end
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    @(posedge clk);
    while (chk0.pending_count() != 0) @(posedge clk);
    #1;
  endtask

  initial begin
    int total;
    clk        = 1'b0;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    op         = '0;
    a          = '0;
    b          = '0;
    out_ready  = 1'b0;
    stall_mode = 1'b0;
    lfsr_state = 32'h124;
    load_table();
    total = 2 * row_s.size();
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // First pass with the output always ready, second with random stalls
    run_rows(1'b1);
    wait_drain();
    stall_mode = 1'b1;
    run_rows(1'b0);
    wait_drain();
    repeat (4) @(posedge clk);
    $display("%0d of %0d tests checked, %0d errors", chk0.test_count, total, chk0.error_count);
    if (chk0.error_count == 0 && chk0.test_count == total) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    int limit;
    #1;
    limit = 2 * row_s.size() * 20 + 100;
    repeat (limit) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("Test failures found");
    $finish;
  end

endmodule

//--- verilog/alu_nibble_slice.sv
`timescale 1ns/1ps
`include "alu_settings.svh"

module alu_nibble_slice (
  input  logic [`ALU_SLICE_WIDTH-1:0] a,
  input  logic [`ALU_SLICE_WIDTH-1:0] b,
  input  logic                        b_invert,
  input  alu_pkg::logic_fn_e          logic_fn,
  input  logic                        carry_in,
  output logic [`ALU_SLICE_WIDTH-1:0] result,
  output logic                        carry_out
);

  logic [`ALU_SLICE_WIDTH-1:0] b_eff;
  logic [`ALU_SLICE_WIDTH-1:0] sum;
  logic [`ALU_SLICE_WIDTH:0]   c;

  assign b_eff = b_invert ? ~b : b;

  // Full adder per bit
  always_comb begin
    c[0] = carry_in;
    for (int k = 0; k < `ALU_SLICE_WIDTH; k++) begin
      sum[k]   = a[k] ^ b_eff[k] ^ c[k];
      c[k + 1] = (a[k] & b_eff[k]) | (c[k] & (a[k] ^ b_eff[k]));
    end
  end

  // Logic modes never carry
  always_comb begin
    case (logic_fn)
      alu_pkg::FN_AND: begin
        result    = a & b_eff;
        carry_out = 1'b0;
      end
      alu_pkg::FN_OR: begin
        result    = a | b_eff;
        carry_out = 1'b0;
      end
      alu_pkg::FN_ADD: begin
        result    = sum;
        carry_out = c[`ALU_SLICE_WIDTH];
      end
      default: begin
        result    = '0;
        carry_out = 1'b0;
      end
    endcase
  end

endmodule

//--- verilog/alu_operand_stage.sv
`timescale 1ns/1ps
`include "alu_settings.svh"

module alu_operand_stage (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     in_valid,
  output logic                     in_ready,
  input  alu_pkg::alu_op_e         op,
  input  logic [`ALU_WIDTH-1:0]    a,
  input  logic [`ALU_WIDTH-1:0]    b,
  input  logic                     advance,
  output logic                     stage_valid,
  output alu_pkg::alu_op_e         stage_op,
  output logic [`ALU_WIDTH-1:0]    slice_a,
  output logic [`ALU_WIDTH-1:0]    slice_b,
  output logic                     b_invert,
  output logic                     carry_in,
  output alu_pkg::logic_fn_e       logic_fn,
  output logic                     a_msb,
  output logic                     b_msb
);

  logic                      shamt_sat;
  logic [`ALU_SHAMT_BITS-1:0] shamt;
  logic [`ALU_WIDTH-1:0]     shl_val;
  logic [`ALU_WIDTH-1:0]     shr_val;
  logic [`ALU_WIDTH-1:0]     sra_val;
  logic [`ALU_WIDTH-1:0]     nxt_a;
  logic [`ALU_WIDTH-1:0]     nxt_b;
  logic                      nxt_inv;
  logic                      nxt_cin;
  alu_pkg::logic_fn_e        nxt_fn;

  // Both stages move together
  assign in_ready = advance;

  ////////////////////////////////////////////////////////////////////////////
  // Shifter ahead of the datapath
  ////////////////////////////////////////////////////////////////////////////

  // Any set bit above the low shift bits means the whole word shifts out
  assign shamt_sat = |b[`ALU_WIDTH-1:`ALU_SHAMT_BITS];
  assign shamt     = b[`ALU_SHAMT_BITS-1:0];

  always_comb begin
    shl_val = a << shamt;
    shr_val = a >> shamt;
    // Kept apart from the saturation mux so the shift stays signed
    sra_val = $signed(a) >>> shamt;
    if (shamt_sat) begin
      shl_val = '0;
      shr_val = '0;
      sra_val = {`ALU_WIDTH{a[`ALU_WIDTH-1]}};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Op decode into slice controls
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    nxt_a   = a;
    nxt_b   = b;
    nxt_inv = 1'b0;
    nxt_cin = 1'b0;
    nxt_fn  = alu_pkg::FN_ADD;
    case (op)
      alu_pkg::ALU_SUB,
      alu_pkg::ALU_SLE: begin
        // Two's complement of b
        nxt_inv = 1'b1;
        nxt_cin = 1'b1;
      end
      alu_pkg::ALU_ADD: begin
        nxt_fn = alu_pkg::FN_ADD;
      end
      alu_pkg::ALU_OR:  nxt_fn = alu_pkg::FN_OR;
      alu_pkg::ALU_AND: nxt_fn = alu_pkg::FN_AND;
      alu_pkg::ALU_DEC: begin
        // a plus the complement of one
        nxt_b   = `ALU_WIDTH'(1);
        nxt_inv = 1'b1;
        nxt_cin = 1'b1;
      end
      alu_pkg::ALU_INC: nxt_b = `ALU_WIDTH'(1);
      alu_pkg::ALU_INV: begin
        // a goes through the b inverter with zero on the a side
        nxt_a   = '0;
        nxt_b   = a;
        nxt_inv = 1'b1;
      end
      alu_pkg::ALU_SLA,
      alu_pkg::ALU_SLL: begin
        nxt_a = shl_val;
        nxt_b = '0;
      end
      alu_pkg::ALU_SRA: begin
        nxt_a = sra_val;
        nxt_b = '0;
      end
      alu_pkg::ALU_SRL: begin
        nxt_a = shr_val;
        nxt_b = '0;
      end
      default: begin
        nxt_a = '0;
        nxt_b = '0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_valid <= 1'b0;
    end else if (advance) begin
      stage_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance && in_valid) begin
      stage_op <= op;
      slice_a  <= nxt_a;
      slice_b  <= nxt_b;
      b_invert <= nxt_inv;
      carry_in <= nxt_cin;
      logic_fn <= nxt_fn;
      a_msb    <= a[`ALU_WIDTH-1];
      b_msb    <= b[`ALU_WIDTH-1];
    end
  end

  // Upstream must hold a pending operation until it is taken
  a_input_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    in_valid && !in_ready |=> in_valid && $stable(op) && $stable(a) && $stable(b)
  );

endmodule

//--- verilog/alu_pkg.sv
`include "alu_settings.svh"

package alu_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Op codes
  //////////////////////////////////////////////////////////////////////////

  // Codes 12 to 15 are left unnamed and give a zero result
  typedef enum logic [`ALU_OP_WIDTH-1:0] {
    ALU_SUB = 0,
    ALU_ADD = 1,
    ALU_OR  = 2,
    ALU_AND = 3,
    ALU_DEC = 4,
    ALU_INC = 5,
    ALU_INV = 6,
    ALU_SLA = 7,
    ALU_SRA = 8,
    ALU_SLL = 9,
    ALU_SRL = 10,
    ALU_SLE = 11
  } alu_op_e;

  //////////////////////////////////////////////////////////////////////////
  // Slice function select
  //////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    FN_AND = 0,
    FN_OR  = 1,
    FN_ADD = 2
  } logic_fn_e;

endpackage

//--- verilog/alu_result_stage.sv
`timescale 1ns/1ps
`include "alu_settings.svh"

module alu_result_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  stage_valid,
  input  alu_pkg::alu_op_e      stage_op,
  input  logic [`ALU_WIDTH-1:0] raw_result,
  input  logic                  carry_out,
  input  logic                  a_msb,
  input  logic                  b_msb,
  output logic                  advance,
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic [`ALU_WIDTH-1:0] s,
  output logic                  overflow,
  output logic                  zero
);

  logic                  started;
  logic                  sle_bit;
  logic                  add_ovf;
  logic [`ALU_WIDTH-1:0] final_word;
  logic                  final_ovf;

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline advance
  ////////////////////////////////////////////////////////////////////////////

  // Holds the pipeline idle for one cycle out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      started <= 1'b0;
    end else begin
      started <= 1'b1;
    end
  end

  // Moves when the output slot is free or being drained
  assign advance = started && (!out_valid || out_ready);

  ////////////////////////////////////////////////////////////////////////////
  // Result select and flags
  ////////////////////////////////////////////////////////////////////////////

  // a-b is zero or negative
  assign sle_bit = ~(|raw_result) | raw_result[`ALU_WIDTH-1];

  // Same operand signs and a different result sign
  assign add_ovf = (a_msb & b_msb & ~raw_result[`ALU_WIDTH-1]) |
                   (~a_msb & ~b_msb & raw_result[`ALU_WIDTH-1]);

  always_comb begin
    final_word = raw_result;
    final_ovf  = 1'b0;
    case (stage_op)
      alu_pkg::ALU_SUB,
      alu_pkg::ALU_DEC,
      alu_pkg::ALU_INC: begin
        final_ovf = carry_out;
      end
      alu_pkg::ALU_ADD: begin
        final_ovf = add_ovf;
      end
      alu_pkg::ALU_OR,
      alu_pkg::ALU_AND,
      alu_pkg::ALU_INV,
      alu_pkg::ALU_SLA,
      alu_pkg::ALU_SRA,
      alu_pkg::ALU_SLL,
      alu_pkg::ALU_SRL: begin
        final_ovf = 1'b0;
      end
      alu_pkg::ALU_SLE: begin
        final_word = {{(`ALU_WIDTH-1){1'b0}}, sle_bit};
        final_ovf  = carry_out;
      end
      // Unused codes
      default: begin
        final_word = '0;
        final_ovf  = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (advance) begin
      out_valid <= stage_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance && stage_valid) begin
      s        <= final_word;
      overflow <= final_ovf;
      zero     <= ~(|final_word);
    end
  end

  // A stalled result stays put until taken
  a_output_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=>
      out_valid && $stable(s) && $stable(overflow) && $stable(zero)
  );

endmodule

//--- verilog/alu_settings.svh
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath sizing
////////////////////////////////////////////////////////////////////////////

// Data word width
`define ALU_WIDTH 16

// Bits handled by one adder/logic slice
`define ALU_SLICE_WIDTH 4

// Slices across the word
`define ALU_NUM_SLICES (`ALU_WIDTH / `ALU_SLICE_WIDTH)

////////////////////////////////////////////////////////////////////////////
// Control sizing
////////////////////////////////////////////////////////////////////////////

`define ALU_OP_WIDTH 4

// Shift amounts at or above 2**ALU_SHAMT_BITS saturate
`define ALU_SHAMT_BITS 4

`endif

//--- verilog/alu_top.v
`timescale 1ns/1ps
`include "alu_settings.svh"

module alu_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     in_valid,
  output logic                     in_ready,
  input  logic [`ALU_OP_WIDTH-1:0] op,
  input  logic [`ALU_WIDTH-1:0]    a,
  input  logic [`ALU_WIDTH-1:0]    b,
  output logic                     out_valid,
  input  logic                     out_ready,
  output logic [`ALU_WIDTH-1:0]    s,
  output logic                     overflow,
  output logic                     zero
);

  logic                        advance;
  logic                        stage_valid;
  alu_pkg::alu_op_e            stage_op;
  logic [`ALU_WIDTH-1:0]       slice_a;
  logic [`ALU_WIDTH-1:0]       slice_b;
  logic                        b_invert;
  alu_pkg::logic_fn_e          logic_fn;
  logic                        a_msb;
  logic                        b_msb;
  logic [`ALU_WIDTH-1:0]       raw_result;
  // Ripple chain, bit 0 in from the operand stage and top bit out
  logic [`ALU_NUM_SLICES:0]    carry;

  alu_operand_stage u_operand (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .op          (alu_pkg::alu_op_e'(op)),
    .a           (a),
    .b           (b),
    .advance     (advance),
    .stage_valid (stage_valid),
    .stage_op    (stage_op),
    .slice_a     (slice_a),
    .slice_b     (slice_b),
    .b_invert    (b_invert),
    .carry_in    (carry[0]),
    .logic_fn    (logic_fn),
    .a_msb       (a_msb),
    .b_msb       (b_msb)
  );

  genvar i;
  generate
    for (i = 0; i < `ALU_NUM_SLICES; i++) begin : g_slice
      alu_nibble_slice u_slice (
        .a         (slice_a[i*`ALU_SLICE_WIDTH +: `ALU_SLICE_WIDTH]),
        .b         (slice_b[i*`ALU_SLICE_WIDTH +: `ALU_SLICE_WIDTH]),
        .b_invert  (b_invert),
        .logic_fn  (logic_fn),
        .carry_in  (carry[i]),
        .result    (raw_result[i*`ALU_SLICE_WIDTH +: `ALU_SLICE_WIDTH]),
        .carry_out (carry[i+1])
      );
    end
  endgenerate

  alu_result_stage u_result (
    .clk         (clk),
    .rst_n       (rst_n),
    .stage_valid (stage_valid),
    .stage_op    (stage_op),
    .raw_result  (raw_result),
    .carry_out   (carry[`ALU_NUM_SLICES]),
    .a_msb       (a_msb),
    .b_msb       (b_msb),
    .advance     (advance),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .s           (s),
    .overflow    (overflow),
    .zero        (zero)
  );

endmodule
